// File: source/zynq_host_pkg.sv
`default_nettype none

package zynq_host_pkg;

  ////////////////////
  // host register port

  localparam int host_data_width_gp = 32;
  localparam int host_addr_width_gp = 3;

  // writable registers, addresses 0 to 3
  localparam int csr_reset_gp     = 0;
  localparam int csr_bitbang_gp   = 1;
  localparam int csr_dram_base_gp = 2;
  localparam int csr_rom_addr_gp  = 3;
  localparam int num_csr_gp       = 4;

  // status registers, read above the writable block
  localparam int stat_xlate_count_gp = 0;
  localparam int stat_rom_data_gp    = 1;

  ////////////////////
  // cache dma and memory

  localparam int dma_addr_width_gp = 24;
  localparam int lg_num_cache_gp   = 3;
  localparam int mem_addr_width_gp = 32;

  ////////////////////
  // defaults for the top level

  localparam int rom_els_gp     = 8;
  localparam int reset_depth_gp = 3;

endpackage

`default_nettype wire

// File: source/config_rom.sv
`timescale 1ns/10ps
`default_nettype none

module config_rom
  #(parameter int rom_els_p = zynq_host_pkg::rom_els_gp)
  (  input  logic [zynq_host_pkg::host_data_width_gp-1:0] addr_i
   , output logic [zynq_host_pkg::host_data_width_gp-1:0] data_o
   );

  import zynq_host_pkg::*;

  always_comb
    begin
      data_o = '0;
      if (addr_i < rom_els_p)
        begin
          case (addr_i)
            0: data_o = 32'h0001_0000;
            1: data_o = 32'd4;
            2: data_o = 32'd4;
            3: data_o = host_data_width_gp'(2**lg_num_cache_gp);
            4: data_o = host_data_width_gp'(dma_addr_width_gp);
            5: data_o = host_data_width_gp'(mem_addr_width_gp);
            // host space below this address
            6: data_o = 32'h0020_0000;
            7: data_o = 32'hB1AD_0001;
            default: data_o = '0;
          endcase
        end
    end

endmodule

`default_nettype wire

// File: source/tag_bitbang.sv
`timescale 1ns/10ps
`default_nettype none

module tag_bitbang
  (  input  logic aclk
   , input  logic reset_i

   , input  logic data_i
   , input  logic v_i
   , output logic ready_o

   , output logic tag_clk_o
   , output logic tag_data_o
   );

  localparam logic [1:0] s_idle  = 2'd0;
  localparam logic [1:0] s_setup = 2'd1;
  localparam logic [1:0] s_high  = 2'd2;

  logic [1:0] state_r;
  logic       clk_r;
  logic       data_r;

  // data leads the rising tag clock by one cycle
  always_ff @(posedge aclk)
    begin
      if (reset_i)
        begin
          state_r <= s_idle;
          clk_r   <= 1'b0;
          data_r  <= 1'b0;
        end
      else
        begin
          case (state_r)
            s_idle:
              begin
                if (v_i)
                  begin
                    data_r  <= data_i;
                    state_r <= s_setup;
                  end
              end
            s_setup:
              begin
                clk_r   <= 1'b1;
                state_r <= s_high;
              end
            default:
              begin
                clk_r   <= 1'b0;
                state_r <= s_idle;
              end
          endcase
        end
    end

  assign ready_o    = (state_r == s_idle);
  assign tag_clk_o  = clk_r;
  assign tag_data_o = data_r;

endmodule

`default_nettype wire

// File: source/dram_addr_map.sv
`timescale 1ns/10ps
`default_nettype none

module dram_addr_map
  (  input  logic                                        aclk
   , input  logic                                        reset_i

   , input  logic [zynq_host_pkg::mem_addr_width_gp-1:0]  dram_base_i

   , input  logic                                        dma_req_i
   , input  logic [zynq_host_pkg::lg_num_cache_gp-1:0]    dma_cache_id_i
   , input  logic [zynq_host_pkg::dma_addr_width_gp-1:0]  dma_addr_i
   , output logic                                        dma_ack_o

   , output logic                                        mem_req_o
   , output logic [zynq_host_pkg::mem_addr_width_gp-1:0]  mem_addr_o
   , input  logic                                        mem_ack_i

   , output logic [zynq_host_pkg::host_data_width_gp-1:0] xlate_count_o
   );

  import zynq_host_pkg::*;

  // line address bits kept below the cache id
  localparam int low_bits_lp = dma_addr_width_gp - lg_num_cache_gp;

  logic [mem_addr_width_gp-1:0]  line_addr;
  logic [mem_addr_width_gp-1:0]  addr_r;
  logic [host_data_width_gp-1:0] count_r;
  logic                          mem_req_r;
  logic                          dma_ack_r;
  logic                          idle;

  assign line_addr = mem_addr_width_gp'({dma_cache_id_i, dma_addr_i[low_bits_lp-1:0]});
  assign idle      = ~mem_req_r & ~dma_ack_r & ~mem_ack_i;

  always_ff @(posedge aclk)
    begin
      if (reset_i)
        begin
          mem_req_r <= 1'b0;
          dma_ack_r <= 1'b0;
          count_r   <= '0;
        end
      else
        begin
          // ack toward the cache trails the memory ack by one cycle
          dma_ack_r <= mem_ack_i;
          if (idle & dma_req_i)
            mem_req_r <= 1'b1;
          else if (mem_req_r & ~dma_req_i)
            mem_req_r <= 1'b0;
          if (mem_ack_i & ~dma_ack_r)
            count_r <= count_r + 1'b1;
        end
    end

  always_ff @(posedge aclk)
    begin
      if (idle & dma_req_i)
        addr_r <= line_addr + dram_base_i;
    end

  assign mem_req_o     = mem_req_r;
  assign mem_addr_o    = addr_r;
  assign dma_ack_o     = dma_ack_r;
  assign xlate_count_o = count_r;

endmodule

`default_nettype wire

// File: source/csr_shell.sv
`timescale 1ns/10ps
`default_nettype none

module csr_shell
  #(parameter int reset_depth_p = zynq_host_pkg::reset_depth_gp)
  (  input  logic                                       aclk
   , input  logic                                       reset_i

   , input  logic                                       host_req_i
   , input  logic                                       host_we_i
   , input  logic [zynq_host_pkg::host_addr_width_gp-1:0] host_addr_i
   , input  logic [zynq_host_pkg::host_data_width_gp-1:0] host_wdata_i
   , output logic                                       host_ack_o
   , output logic [zynq_host_pkg::host_data_width_gp-1:0] host_rdata_o

   , output logic                                       bb_data_o
   , output logic                                       bb_v_o
   , output logic [zynq_host_pkg::mem_addr_width_gp-1:0]  dram_base_o
   , output logic [zynq_host_pkg::host_data_width_gp-1:0] rom_addr_o
   , output logic                                       machine_reset_o

   , input  logic [zynq_host_pkg::host_data_width_gp-1:0] rom_data_i
   , input  logic [zynq_host_pkg::host_data_width_gp-1:0] xlate_count_i
   );

  import zynq_host_pkg::*;

  localparam int csr_idx_width_lp = $clog2(num_csr_gp);

  logic [host_data_width_gp-1:0] csr_r [num_csr_gp];
  logic [host_data_width_gp-1:0] rdata_mux;
  logic [host_data_width_gp-1:0] rdata_r;
  logic [reset_depth_p-1:0]      rst_chain_r;
  logic                          ack_r;
  logic                          bb_v_r;
  logic                          access_en;
  logic                          csr_we;

  // a new request is served on the edge that raises ack
  assign access_en = host_req_i & ~ack_r;
  assign csr_we    = access_en & host_we_i & (host_addr_i < num_csr_gp);

  always_ff @(posedge aclk)
    begin
      if (reset_i)
        begin
          ack_r  <= 1'b0;
          bb_v_r <= 1'b0;
          for (int i = 0; i < num_csr_gp; i++)
            csr_r[i] <= '0;
        end
      else
        begin
          ack_r  <= host_req_i;
          bb_v_r <= csr_we & (host_addr_i == host_addr_width_gp'(csr_bitbang_gp));
          if (csr_we)
            csr_r[host_addr_i[csr_idx_width_lp-1:0]] <= host_wdata_i;
        end
    end

  ////////////////////
  // readback

  always_comb
    begin
      rdata_mux = '0;
      if (host_addr_i < num_csr_gp)
        rdata_mux = csr_r[host_addr_i[csr_idx_width_lp-1:0]];
      else if (host_addr_i == host_addr_width_gp'(num_csr_gp + stat_xlate_count_gp))
        rdata_mux = xlate_count_i;
      else if (host_addr_i == host_addr_width_gp'(num_csr_gp + stat_rom_data_gp))
        rdata_mux = rom_data_i;
    end

  always_ff @(posedge aclk)
    begin
      if (access_en)
        rdata_r <= rdata_mux;
    end

  ////////////////////
  // machine reset release

  // bit 0 of the reset register is an active low reset for the machine
  always_ff @(posedge aclk)
    begin
      if (reset_i)
        rst_chain_r <= '1;
      else
        begin
          rst_chain_r[0] <= ~csr_r[csr_reset_gp][0];
          for (int i = 1; i < reset_depth_p; i++)
            rst_chain_r[i] <= rst_chain_r[i-1];
        end
    end

  assign host_ack_o      = ack_r;
  assign host_rdata_o    = rdata_r;
  assign bb_data_o       = csr_r[csr_bitbang_gp][0];
  assign bb_v_o          = bb_v_r;
  assign dram_base_o     = csr_r[csr_dram_base_gp];
  assign rom_addr_o      = csr_r[csr_rom_addr_gp];
  assign machine_reset_o = rst_chain_r[reset_depth_p-1];

endmodule

`default_nettype wire

// File: source/zynq_host_top.sv
`timescale 1ns/10ps
`default_nettype none

module zynq_host_top
  (  input  logic                                        aclk
   , input  logic                                        reset_i

   , input  logic                                        host_req_i
   , input  logic                                        host_we_i
   , input  logic [zynq_host_pkg::host_addr_width_gp-1:0] host_addr_i
   , input  logic [zynq_host_pkg::host_data_width_gp-1:0] host_wdata_i
   , output logic                                        host_ack_o
   , output logic [zynq_host_pkg::host_data_width_gp-1:0] host_rdata_o

   , output logic                                        tag_clk_o
   , output logic                                        tag_data_o
   , output logic                                        machine_reset_o

   , input  logic                                        dma_req_i
   , input  logic [zynq_host_pkg::lg_num_cache_gp-1:0]    dma_cache_id_i
   , input  logic [zynq_host_pkg::dma_addr_width_gp-1:0]  dma_addr_i
   , output logic                                        dma_ack_o

   , output logic                                        mem_req_o
   , output logic [zynq_host_pkg::mem_addr_width_gp-1:0]  mem_addr_o
   , input  logic                                        mem_ack_i
   );

  import zynq_host_pkg::*;

  logic                          bb_data;
  logic                          bb_v;
  logic                          bb_ready;
  logic [mem_addr_width_gp-1:0]  dram_base;
  logic [host_data_width_gp-1:0] rom_addr;
  logic [host_data_width_gp-1:0] rom_data;
  logic [host_data_width_gp-1:0] xlate_count;
  logic                          machine_reset;

  ////////////////////
  // host registers

  csr_shell
   #(.reset_depth_p(reset_depth_gp))
   u_csr
    (.aclk            (aclk)
     ,.reset_i        (reset_i)
     ,.host_req_i     (host_req_i)
     ,.host_we_i      (host_we_i)
     ,.host_addr_i    (host_addr_i)
     ,.host_wdata_i   (host_wdata_i)
     ,.host_ack_o     (host_ack_o)
     ,.host_rdata_o   (host_rdata_o)
     ,.bb_data_o      (bb_data)
     ,.bb_v_o         (bb_v)
     ,.dram_base_o    (dram_base)
     ,.rom_addr_o     (rom_addr)
     ,.machine_reset_o(machine_reset)
     ,.rom_data_i     (rom_data)
     ,.xlate_count_i  (xlate_count)
     );

  config_rom
   #(.rom_els_p(rom_els_gp))
   u_rom
    (.addr_i  (rom_addr)
     ,.data_o (rom_data)
     );

  // software polls, a bit sent while busy is dropped
  tag_bitbang
   u_bb
    (.aclk       (aclk)
     ,.reset_i   (reset_i)
     ,.data_i    (bb_data)
     ,.v_i       (bb_v & bb_ready)
     ,.ready_o   (bb_ready)
     ,.tag_clk_o (tag_clk_o)
     ,.tag_data_o(tag_data_o)
     );

  ////////////////////
  // dram address map

  dram_addr_map
   u_map
    (.aclk           (aclk)
     ,.reset_i       (machine_reset)
     ,.dram_base_i   (dram_base)
     ,.dma_req_i     (dma_req_i)
     ,.dma_cache_id_i(dma_cache_id_i)
     ,.dma_addr_i    (dma_addr_i)
     ,.dma_ack_o     (dma_ack_o)
     ,.mem_req_o     (mem_req_o)
     ,.mem_addr_o    (mem_addr_o)
     ,.mem_ack_i     (mem_ack_i)
     ,.xlate_count_o (xlate_count)
     );

  assign machine_reset_o = machine_reset;

endmodule

`default_nettype wire

// File: bench/zynq_host_properties.sv
`timescale 1ns/10ps
`default_nettype none

module zynq_host_properties
  #(parameter int reset_depth_p = zynq_host_pkg::reset_depth_gp)
  (  input  logic                                        aclk
   , input  logic                                        reset_i
   , input  logic                                        host_req_i
   , input  logic                                        host_we_i
   , input  logic [zynq_host_pkg::host_addr_width_gp-1:0] host_addr_i
   , input  logic [zynq_host_pkg::host_data_width_gp-1:0] host_wdata_i
   , input  logic                                        host_ack_o
   , input  logic [zynq_host_pkg::host_data_width_gp-1:0] host_rdata_o
   , input  logic                                        tag_clk_o
   , input  logic                                        tag_data_o
   , input  logic                                        machine_reset_o
   , input  logic                                        dma_req_i
   , input  logic [zynq_host_pkg::lg_num_cache_gp-1:0]    dma_cache_id_i
   , input  logic [zynq_host_pkg::dma_addr_width_gp-1:0]  dma_addr_i
   , input  logic                                        dma_ack_o
   , input  logic                                        mem_req_o
   , input  logic [zynq_host_pkg::mem_addr_width_gp-1:0]  mem_addr_o
   , input  logic                                        mem_ack_i
   );

  import zynq_host_pkg::*;

  int fail_count = 0;

  logic [host_data_width_gp-1:0] shadow_r [num_csr_gp];
  logic [host_data_width_gp-1:0] exp_rdata_r;
  logic [host_data_width_gp-1:0] xlate_r;
  logic [mem_addr_width_gp-1:0]  exp_addr;
  logic                          bb_bit_r;
  logic                          mem_ack_r;
  logic                          accept;
  logic                          wr_accept;
  logic                          rd_accept;

  assign accept    = host_req_i & ~host_ack_o;
  assign wr_accept = accept & host_we_i;
  assign rd_accept = accept & ~host_we_i;

  // cache id goes on top of the low 21 line address bits
  assign exp_addr = shadow_r[csr_dram_base_gp]
                  + {8'b0, dma_cache_id_i, dma_addr_i[20:0]};

  task automatic record_failure(input string msg);
    fail_count++;
    $error("error %0t: %s", $time, msg);
  endtask

  function automatic logic [host_data_width_gp-1:0] rom_word(input logic [31:0] a);
    case (a)
      32'd0: return 32'h0001_0000;
      32'd1: return 32'd4;
      32'd2: return 32'd4;
      32'd3: return 32'd8;
      32'd4: return 32'd24;
      32'd5: return 32'd32;
      32'd6: return 32'h0020_0000;
      32'd7: return 32'hB1AD_0001;
      default: return '0;
    endcase
  endfunction

  function automatic logic [host_data_width_gp-1:0] expect_rdata
    (input logic [host_addr_width_gp-1:0] a);
    if (a < 3'd4)
      return shadow_r[a[1:0]];
    else if (a == 3'(num_csr_gp + stat_xlate_count_gp))
      return xlate_r;
    else if (a == 3'(num_csr_gp + stat_rom_data_gp))
      return rom_word(shadow_r[csr_rom_addr_gp]);
    else
      return '0;
  endfunction

  ////////////////////
  // register model

  always_ff @(posedge aclk)
    begin
      exp_rdata_r <= expect_rdata(host_addr_i);
      mem_ack_r   <= mem_ack_i;
      if (reset_i)
        begin
          for (int i = 0; i < num_csr_gp; i++)
            shadow_r[i] <= '0;
          bb_bit_r <= 1'b0;
        end
      else if (wr_accept && host_addr_i < 3'd4)
        begin
          shadow_r[host_addr_i[1:0]] <= host_wdata_i;
          if (host_addr_i == 3'(csr_bitbang_gp))
            bb_bit_r <= host_wdata_i[0];
        end
      // one translation per rising memory ack
      if (machine_reset_o)
        xlate_r <= '0;
      else if (mem_ack_i && !mem_ack_r)
        xlate_r <= xlate_r + 1;
    end

  ////////////////////
  // checks

  a_reset_values : assert property (@(posedge aclk)
      $fell(reset_i) |-> !host_ack_o && !mem_req_o && !dma_ack_o && !tag_clk_o
                         && machine_reset_o)
    else record_failure("outputs not at their reset values");

  a_ack_needs_req : assert property (@(posedge aclk) disable iff (reset_i)
      $rose(host_ack_o) |-> $past(host_req_i))
    else record_failure("host ack rose without a request");

  a_ack_latency : assert property (@(posedge aclk) disable iff (reset_i)
      $rose(host_req_i) |=> $rose(host_ack_o))
    else record_failure("host ack did not rise one cycle after the request");

  a_readback : assert property (@(posedge aclk) disable iff (reset_i)
      rd_accept |=> host_rdata_o == exp_rdata_r)
    else record_failure("host readback differs from the register model");

  a_held_in_reset : assert property (@(posedge aclk) disable iff (reset_i)
      !shadow_r[csr_reset_gp][0] |-> machine_reset_o)
    else record_failure("machine reset released without a write");

  a_release : assert property (@(posedge aclk) disable iff (reset_i)
      wr_accept && host_addr_i == 3'(csr_reset_gp) && host_wdata_i[0]
      && !shadow_r[csr_reset_gp][0] |-> ##(reset_depth_p+1) $fell(machine_reset_o))
    else record_failure("machine reset release latency wrong");

  a_map_quiet : assert property (@(posedge aclk) disable iff (reset_i)
      machine_reset_o |-> !mem_req_o)
    else record_failure("memory request during machine reset");

  a_mem_req_needs_dma : assert property (@(posedge aclk) disable iff (reset_i)
      $rose(mem_req_o) |-> $past(dma_req_i))
    else record_failure("memory request rose without a dma request");

  a_mem_req_latency : assert property (@(posedge aclk)
      disable iff (reset_i || machine_reset_o)
      $rose(dma_req_i) |=> $rose(mem_req_o))
    else record_failure("memory request did not rise one cycle after dma request");

  a_dma_ack_latency : assert property (@(posedge aclk)
      disable iff (reset_i || machine_reset_o)
      $rose(mem_ack_i) |=> $rose(dma_ack_o))
    else record_failure("dma ack did not rise one cycle after the memory ack");

  a_mem_addr : assert property (@(posedge aclk) disable iff (reset_i)
      mem_req_o |-> mem_addr_o == exp_addr)
    else record_failure("memory address breaks the address rule");

  a_tag_bit : assert property (@(posedge aclk) disable iff (reset_i)
      $rose(tag_clk_o) |-> tag_data_o == bb_bit_r)
    else record_failure("tag data at the tag clock edge is not the written bit");

endmodule

bind zynq_host_top zynq_host_properties
  #(.reset_depth_p(zynq_host_pkg::reset_depth_gp))
  u_props
   (.aclk            (aclk)
    ,.reset_i        (reset_i)
    ,.host_req_i     (host_req_i)
    ,.host_we_i      (host_we_i)
    ,.host_addr_i    (host_addr_i)
    ,.host_wdata_i   (host_wdata_i)
    ,.host_ack_o     (host_ack_o)
    ,.host_rdata_o   (host_rdata_o)
    ,.tag_clk_o      (tag_clk_o)
    ,.tag_data_o     (tag_data_o)
    ,.machine_reset_o(machine_reset_o)
    ,.dma_req_i      (dma_req_i)
    ,.dma_cache_id_i (dma_cache_id_i)
    ,.dma_addr_i     (dma_addr_i)
    ,.dma_ack_o      (dma_ack_o)
    ,.mem_req_o      (mem_req_o)
    ,.mem_addr_o     (mem_addr_o)
    ,.mem_ack_i      (mem_ack_i)
    );

`default_nettype wire

// File: bench/tb_zynq_host.sv
`timescale 1ns/10ps
`default_nettype none

module tb_zynq_host;

  import zynq_host_pkg::*;

  // held dma, release, register pass, rom sweep, tag bits, base write, dma, count read
  localparam int num_ops_lp    = 1 + 1 + 10 + 20 + 8 + 1 + 20 + 1;
  localparam int timeout_ns_lp = num_ops_lp * 200 + 2000;

  logic                          aclk;
  logic                          reset_i;
  logic                          host_req_i;
  logic                          host_we_i;
  logic [host_addr_width_gp-1:0] host_addr_i;
  logic [host_data_width_gp-1:0] host_wdata_i;
  logic                          host_ack_o;
  logic [host_data_width_gp-1:0] host_rdata_o;
  logic                          tag_clk_o;
  logic                          tag_data_o;
  logic                          machine_reset_o;
  logic                          dma_req_i;
  logic [lg_num_cache_gp-1:0]    dma_cache_id_i;
  logic [dma_addr_width_gp-1:0]  dma_addr_i;
  logic                          dma_ack_o;
  logic                          mem_req_o;
  logic [mem_addr_width_gp-1:0]  mem_addr_o;
  logic                          mem_ack_i;

  logic [31:0] lfsr_r = 32'h85aad32b;
  int          timeouts = 0;

  zynq_host_top u_zynq_host_top (.*);

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
      begin
        fb     = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
        lfsr_r = {lfsr_r[30:0], fb};
        v      = {v[30:0], fb};
      end
    return v;
  endfunction

  task automatic host_access(input logic we, input logic [host_addr_width_gp-1:0] addr,
                             input logic [host_data_width_gp-1:0] wdata);
    @(negedge aclk);
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    while (!host_ack_o)
      @(negedge aclk);
    host_req_i = 1'b0;
    while (host_ack_o)
      @(negedge aclk);
  endtask

  task automatic dma_request(input logic [lg_num_cache_gp-1:0] id,
                             input logic [dma_addr_width_gp-1:0] addr);
    @(negedge aclk);
    dma_cache_id_i = id;
    dma_addr_i     = addr;
    dma_req_i      = 1'b1;
    while (!dma_ack_o)
      @(negedge aclk);
    dma_req_i = 1'b0;
    while (dma_ack_o)
      @(negedge aclk);
  endtask

  task automatic respond_mem();
    while (mem_req_o !== 1'b1)
      @(negedge aclk);
    repeat (rand_bits(2)) @(negedge aclk);
    mem_ack_i = 1'b1;
    while (mem_req_o === 1'b1)
      @(negedge aclk);
    repeat (rand_bits(2)) @(negedge aclk);
    mem_ack_i = 1'b0;
  endtask

  task automatic report_and_finish();
    int failures;
    failures = u_zynq_host_top.u_props.fail_count;
    $display("assertion failures %0d, timeouts %0d", failures, timeouts);
    if (failures == 0 && timeouts == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  endtask

  initial
    begin
      aclk = 1'b0;
      forever #4 aclk = ~aclk;
    end

  initial
    begin
      mem_ack_i = 1'b0;
      forever
        respond_mem();
    end

  initial
    begin
      #(timeout_ns_lp);
      timeouts++;
      $display("timeout: the run did not finish within %0d ns", timeout_ns_lp);
      report_and_finish();
    end

  ////////////////////
  // stimulus

  initial
    begin
      logic [31:0] value;
      reset_i        = 1'b1;
      host_req_i     = 1'b0;
      host_we_i      = 1'b0;
      host_addr_i    = '0;
      host_wdata_i   = '0;
      dma_req_i      = 1'b0;
      dma_cache_id_i = '0;
      dma_addr_i     = '0;
      repeat (5) @(posedge aclk);
      @(negedge aclk);
      reset_i = 1'b0;

      // a dma request while the machine is held must not reach memory
      dma_req_i = 1'b1;
      repeat (6) @(negedge aclk);
      dma_req_i = 1'b0;

      // machine stays held until software writes the release bit
      host_access(1'b1, 3'(csr_reset_gp), 32'd1);
      while (machine_reset_o)
        @(negedge aclk);

      for (int r = 0; r < num_csr_gp; r++)
        begin
          value = rand_bits(32);
          // bit 0 of register 0 keeps the machine out of reset
          if (r == csr_reset_gp)
            value[0] = 1'b1;
          host_access(1'b1, 3'(r), value);
          host_access(1'b0, 3'(r), '0);
        end
      host_access(1'b0, 3'd6, '0);
      host_access(1'b0, 3'd7, '0);

      for (int a = 0; a < 10; a++)
        begin
          host_access(1'b1, 3'(csr_rom_addr_gp), 32'(a));
          host_access(1'b0, 3'(num_csr_gp + stat_rom_data_gp), '0);
        end

      for (int b = 0; b < 8; b++)
        begin
          host_access(1'b1, 3'(csr_bitbang_gp), rand_bits(1));
          repeat (4) @(negedge aclk);
        end

      host_access(1'b1, 3'(csr_dram_base_gp), rand_bits(32));
      for (int d = 0; d < 20; d++)
        dma_request(3'(rand_bits(lg_num_cache_gp)), 24'(rand_bits(dma_addr_width_gp)));
      host_access(1'b0, 3'(num_csr_gp + stat_xlate_count_gp), '0);

      repeat (4) @(negedge aclk);
      report_and_finish();
    end

endmodule

`default_nettype wire

// File: compile.f
source/zynq_host_pkg.sv
source/config_rom.sv
source/tag_bitbang.sv
source/dram_addr_map.sv
source/csr_shell.sv
source/zynq_host_top.sv
bench/zynq_host_properties.sv
bench/tb_zynq_host.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_zynq_host
FILELIST  := compile.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJDIR)
